//--- Makefile
# Verilator build and run for the subword multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_subword_mult
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell sed -n '/^[^+]/p' $(FILELIST)) include/mult_ref_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+include
verilog/mult_pkg.sv
verilog/mulh_step_if.sv
verilog/mulh_ctrl.sv
verilog/short_mac_unit.sv
verilog/int_mac_unit.sv
verilog/dot_mac_unit.sv
verilog/subword_mult.sv
verification/tb_subword_mult.sv

//--- include/mult_ref_model.svh
// Reference functions giving the expected result for each multiplier operator
`ifndef MULT_REF_MODEL_SVH
`define MULT_REF_MODEL_SVH

// Lane of width w taken from the bottom of v, sign or zero extended
function automatic longint ref_ext(input logic [31:0] v, input int w, input logic sgn);
  longint raw;
  raw = longint'(v) & ((longint'(1) << w) - 1);
  if (sgn && raw[w-1]) begin
    raw = raw - (longint'(1) << w);
  end
  return raw;
endfunction

// Product of the selected halves plus C, rounded and shifted
function automatic logic [31:0] ref_short(input logic rnd, input logic [31:0] a,
    input logic [31:0] b, input logic [31:0] c, input logic [4:0] imm,
    input logic sub, input logic [1:0] sgn);
  longint      acc;
  logic [31:0] low;
  acc = ref_ext(sub ? a >> 16 : a, 16, sgn[0]) * ref_ext(sub ? b >> 16 : b, 16, sgn[1]);
  acc = acc + ref_ext(c, 32, 1'b1);
  if (rnd && (imm != 0)) begin
    acc = acc + (longint'(1) << (imm - 1));
  end
  low = acc[31:0];
  return sgn[0] ? 32'($signed(low) >>> imm) : (low >> imm);
endfunction

// Byte or halfword dot product, bit 1 signs A and bit 0 signs B
function automatic logic [31:0] ref_dot(input int w, input logic [31:0] a,
    input logic [31:0] b, input logic [31:0] c, input logic [1:0] sgn);
  longint acc;
  acc = ref_ext(c, 32, 1'b1);
  for (int i = 0; i < 32 / w; i++) begin
    acc = acc + ref_ext(a >> (i * w), w, sgn[1]) * ref_ext(b >> (i * w), w, sgn[0]);
  end
  return acc[31:0];
endfunction

// Expected result by operator
function automatic logic [31:0] ref_result(input mult_pkg::mult_op_e op,
    input logic [31:0] a, input logic [31:0] b, input logic [31:0] c, input logic [4:0] imm,
    input logic sub, input logic [1:0] ssgn, input logic [1:0] dsgn);
  longint      prod;
  logic [63:0] wide;
  prod = ref_ext(a, 32, 1'b0) * ref_ext(b, 32, 1'b0);
  wide = ref_ext(a, 32, ssgn[0]) * ref_ext(b, 32, ssgn[1]);
  case (op)
    mult_pkg::MUL_MAC32: return 32'(ref_ext(c, 32, 1'b0) + prod);
    mult_pkg::MUL_MSU32: return 32'(ref_ext(c, 32, 1'b0) - prod);
    mult_pkg::MUL_I:     return ref_short(1'b0, a, b, c, imm, sub, ssgn);
    mult_pkg::MUL_IR:    return ref_short(1'b1, a, b, c, imm, sub, ssgn);
    mult_pkg::MUL_DOT8:  return ref_dot(8, a, b, c, dsgn);
    mult_pkg::MUL_DOT16: return ref_dot(16, a, b, c, dsgn);
    mult_pkg::MUL_H:     return wide[63:32];
    default:             return 32'd0;
  endcase
endfunction

`endif

//--- verification/tb_subword_mult.sv
// Testbench for the subword multiply-accumulate unit
// Stimulus table with reference results, MUL_H handshake checks and watchdog
`timescale 1ns/1ps

module tb_subword_mult;
  import mult_pkg::*;

  `include "mult_ref_model.svh"

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_RANDOM   = 24;
  // Cycles held in FINISH with ex_ready_i low
  localparam int HOLD_CYCLES  = 3;

  // One table row with stimulus and expected result
  typedef struct packed {
    mult_op_e    op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [4:0]  imm;
    logic        sub;
    logic [1:0]  ssgn;
    logic [1:0]  dsgn;
    logic [31:0] exp;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        enable_i;
  mult_op_e    operator_i;
  logic [31:0] op_a_i;
  logic [31:0] op_b_i;
  logic [31:0] op_c_i;
  logic [4:0]  imm_i;
  logic        short_subword_i;
  logic [1:0]  short_signed_i;
  logic [1:0]  dot_signed_i;
  logic        ex_ready_i;
  logic [31:0] result_o;
  logic        ready_o;
  logic        multicycle_o;

  row_t        rows[$];
  logic [31:0] rng_state;
  int          cycle_count;
  int          cycle_limit = 0;

  subword_mult u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable_i),
    .operator_i      (operator_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .imm_i           (imm_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .dot_signed_i    (dot_signed_i),
    .ex_ready_i      (ex_ready_i),
    .result_o        (result_o),
    .ready_o         (ready_o),
    .multicycle_o    (multicycle_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog whose limit is set once the table is built
  initial begin
    cycle_count = 0;
    while ((cycle_limit == 0) || (cycle_count < cycle_limit)) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // xorshift32 step
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic void add_row(input mult_op_e op, input logic [31:0] a,
      input logic [31:0] b, input logic [31:0] c, input logic [4:0] imm,
      input logic sub, input logic [1:0] ssgn, input logic [1:0] dsgn);
    row_t r;
    r.op   = op;
    r.a    = a;
    r.b    = b;
    r.c    = c;
    r.imm  = imm;
    r.sub  = sub;
    r.ssgn = ssgn;
    r.dsgn = dsgn;
    r.exp  = ref_result(op, a, b, c, imm, sub, ssgn, dsgn);
    rows.push_back(r);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  function automatic void build_table();
    mult_op_e    op;
    logic [31:0] ctl;
    logic [1:0]  ssgn;
    //      op         a             b             c             imm    sub   ssgn   dsgn
    add_row(MUL_MAC32, 32'h00000003, 32'h00000005, 32'h00000007, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_MAC32, 32'hFFFFFFFF, 32'h00000002, 32'h00000001, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_MAC32, 32'h12345678, 32'h9ABCDEF0, 32'h0F0F0F0F, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_MSU32, 32'h00000003, 32'h00000005, 32'h00000007, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_MSU32, 32'h80000000, 32'hFFFFFFFF, 32'h00000000, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_I,     32'h0003FFF0, 32'h00050010, 32'h00000000, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_I,     32'hFFF00003, 32'h80010005, 32'hFFFFFF9C, 5'd3,  1'b1, 2'b11, 2'b00);
    add_row(MUL_I,     32'h0003FFF0, 32'h00058010, 32'h00001000, 5'd4,  1'b0, 2'b11, 2'b00);
    add_row(MUL_I,     32'h8000FFFF, 32'h7FFF0001, 32'h00000000, 5'd31, 1'b1, 2'b01, 2'b00);
    add_row(MUL_I,     32'h1234F00D, 32'h5678C0DE, 32'h00000010, 5'd2,  1'b0, 2'b10, 2'b00);
    add_row(MUL_IR,    32'h0000FFFF, 32'h0000FFFF, 32'h00000000, 5'd0,  1'b0, 2'b11, 2'b00);
    add_row(MUL_IR,    32'hFFF30000, 32'h00070000, 32'h00000005, 5'd5,  1'b1, 2'b11, 2'b00);
    add_row(MUL_IR,    32'h00050000, 32'h00030000, 32'h00000000, 5'd1,  1'b1, 2'b00, 2'b00);
    add_row(MUL_DOT8,  32'h80FF7F01, 32'h7F80FF02, 32'h00000100, 5'd0,  1'b0, 2'b00, 2'b11);
    add_row(MUL_DOT8,  32'h80FF7F01, 32'h7F80FF02, 32'h00000100, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_DOT8,  32'hF0E0D0C0, 32'h01020304, 32'hFFFFFFF0, 5'd0,  1'b0, 2'b00, 2'b10);
    add_row(MUL_DOT8,  32'h01020304, 32'hF0E0D0C0, 32'h00000000, 5'd0,  1'b0, 2'b00, 2'b01);
    add_row(MUL_DOT16, 32'h8000FFFF, 32'h7FFF8000, 32'h00000001, 5'd0,  1'b0, 2'b00, 2'b11);
    add_row(MUL_DOT16, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000003, 5'd0,  1'b0, 2'b00, 2'b00);
    add_row(MUL_DOT16, 32'h1234ABCD, 32'hFEDC0123, 32'hDEADBEEF, 5'd0,  1'b0, 2'b00, 2'b01);
    add_row(MUL_H,     32'hFFFFFFFD, 32'h00000007, 32'h00000000, 5'd0,  1'b0, 2'b11, 2'b00);
    add_row(MUL_H,     32'h80000000, 32'h80000000, 32'h00000000, 5'd0,  1'b0, 2'b11, 2'b00);
    add_row(MUL_H,     32'h87654321, 32'hFEDCBA98, 32'h00000000, 5'd0,  1'b0, 2'b01, 2'b00);
    add_row(MUL_H,     32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000000, 5'd0,  1'b0, 2'b00, 2'b00);
    // Random rows without signed pair 10 for MUL_H
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op   = mult_op_e'(next_rand() % 7);
      ctl  = next_rand();
      ssgn = ctl[6:5];
      if ((op == MUL_H) && (ssgn == 2'b10)) begin
        ssgn = 2'b11;
      end
      add_row(op, next_rand(), next_rand(), next_rand(), ctl[4:0], ctl[7], ssgn, ctl[9:8]);
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Row execution entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic drive_row(input row_t r);
    enable_i        = 1'b1;
    operator_i      = r.op;
    op_a_i          = r.a;
    op_b_i          = r.b;
    op_c_i          = r.c;
    imm_i           = r.imm;
    short_subword_i = r.sub;
    short_signed_i  = r.ssgn;
    dot_signed_i    = r.dsgn;
  endtask

  task automatic run_comb(input row_t r);
    drive_row(r);
    @(negedge clk);
    check_value("result_o", result_o, r.exp);
    check_value("ready_o", 32'(ready_o), 32'd1);
    check_value("multicycle_o", 32'(multicycle_o), 32'd0);
  endtask

  task automatic run_mulh(input row_t r);
    int cycles;
    int mc_cycles;
    cycles     = 0;
    mc_cycles  = 0;
    ex_ready_i = 1'b0;
    drive_row(r);
    // Ready drops in the accepting cycle
    #(CLK_PERIOD / 4);
    check_value("ready_o on accept", 32'(ready_o), 32'd0);
    check_value("multicycle_o on accept", 32'(multicycle_o), 32'd0);
    do begin
      @(negedge clk);
      cycles++;
      if (multicycle_o) begin
        mc_cycles++;
      end
    end while (!ready_o);
    check_value("MUL_H latency", cycles, 32'd4);
    check_value("multicycle_o cycles", mc_cycles, 32'd3);
    check_value("result_o", result_o, r.exp);
    // Back-pressure holds the result
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value("ready_o held", 32'(ready_o), 32'd1);
      check_value("multicycle_o held", 32'(multicycle_o), 32'd0);
      check_value("result_o held", result_o, r.exp);
    end
    // Request stays up so that the return to IDLE shows as a fresh accept
    ex_ready_i = 1'b1;
    @(negedge clk);
    check_value("ready_o after release", 32'(ready_o), 32'd0);
    check_value("multicycle_o after release", 32'(multicycle_o), 32'd0);
    // Withdraw the request before it starts
    enable_i = 1'b0;
  endtask

  initial begin
    rng_state       = 32'd13406;
    rst_n           = 1'b0;
    enable_i        = 1'b0;
    operator_i      = MUL_MAC32;
    op_a_i          = '0;
    op_b_i          = '0;
    op_c_i          = '0;
    imm_i           = '0;
    short_subword_i = 1'b0;
    short_signed_i  = 2'b00;
    dot_signed_i    = 2'b00;
    ex_ready_i      = 1'b1;
    build_table();
    cycle_limit = rows.size() * 8 + 50;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("ready_o after reset", 32'(ready_o), 32'd1);
    check_value("multicycle_o after reset", 32'(multicycle_o), 32'd0);
    foreach (rows[i]) begin
      if (rows[i].op == MUL_H) begin
        run_mulh(rows[i]);
      end else begin
        run_comb(rows[i]);
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

//--- verilog/dot_mac_unit.sv
// 8-bit and 16-bit dot products with accumulation
`timescale 1ns/1ps

module dot_mac_unit (
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  input  logic [1:0]                  dot_signed_i,
  output logic [mult_pkg::DATA_W-1:0] dot8_result_o,
  output logic [mult_pkg::DATA_W-1:0] dot16_result_o
);
  import mult_pkg::*;

  // Byte lanes with one sign bit
  logic [DATA_W/8-1:0][8:0]       char_a;
  logic [DATA_W/8-1:0][8:0]       char_b;
  logic [DATA_W/8-1:0][17:0]      char_mul;
  // Halfword lanes with one sign bit
  logic [DATA_W/HALF_W-1:0][HALF_W:0]   half_a;
  logic [DATA_W/HALF_W-1:0][HALF_W:0]   half_b;
  logic [DATA_W/HALF_W-1:0][DATA_W+1:0] half_mul;

  ////////////////////////////////////////////////////////////
  // Lane products
  ////////////////////////////////////////////////////////////

  // Bit 1 signs A, bit 0 signs B
  for (genvar i = 0; i < DATA_W / 8; i++) begin : g_char
    assign char_a[i]   = {dot_signed_i[1] & op_a_i[8*i+7], op_a_i[8*i +: 8]};
    assign char_b[i]   = {dot_signed_i[0] & op_b_i[8*i+7], op_b_i[8*i +: 8]};
    assign char_mul[i] = $signed(char_a[i]) * $signed(char_b[i]);
  end

  for (genvar i = 0; i < DATA_W / HALF_W; i++) begin : g_half
    assign half_a[i]   = {dot_signed_i[1] & op_a_i[HALF_W*i+HALF_W-1], op_a_i[HALF_W*i +: HALF_W]};
    assign half_b[i]   = {dot_signed_i[0] & op_b_i[HALF_W*i+HALF_W-1], op_b_i[HALF_W*i +: HALF_W]};
    assign half_mul[i] = $signed(half_a[i]) * $signed(half_b[i]);
  end

  ////////////////////////////////////////////////////////////
  // Reduction onto the accumulator
  ////////////////////////////////////////////////////////////

  always_comb begin
    dot8_result_o = op_c_i;
    // Byte products sign-extended to the word
    for (int i = 0; i < DATA_W / 8; i++) begin
      dot8_result_o = dot8_result_o + DATA_W'($signed(char_mul[i]));
    end
  end

  always_comb begin
    dot16_result_o = op_c_i;
    // Only the low word of each product reaches the result
    for (int i = 0; i < DATA_W / HALF_W; i++) begin
      dot16_result_o = dot16_result_o + half_mul[i][DATA_W-1:0];
    end
  end

endmodule

//--- verilog/int_mac_unit.sv
// 32-bit multiply-accumulate and multiply-subtract
`timescale 1ns/1ps

module int_mac_unit (
  input  mult_pkg::mult_op_e          operator_i,
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  output logic [mult_pkg::DATA_W-1:0] int_result_o
);
  import mult_pkg::*;

  logic              is_msu;
  // A inverted for subtract
  logic [DATA_W-1:0] op_a_msu;
  // B added back to complete the negation
  logic [DATA_W-1:0] op_b_msu;

  assign is_msu = (operator_i == MUL_MSU32);

  ////////////////////////////////////////////////////////////
  // C - A*B rewritten as C + (~A)*B + B
  ////////////////////////////////////////////////////////////

  assign op_a_msu = op_a_i ^ {DATA_W{is_msu}};
  assign op_b_msu = op_b_i & {DATA_W{is_msu}};

  // Low word only, sign does not matter
  assign int_result_o = op_c_i + op_b_msu + op_a_msu * op_b_i;

endmodule

//--- verilog/mulh_ctrl.sv
// High-multiply FSM with the carry register
// Drives the ready and multicycle outputs
`timescale 1ns/1ps

module mulh_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable_i,
  input  mult_pkg::mult_op_e operator_i,
  input  logic [1:0]         short_signed_i,
  input  logic               ex_ready_i,
  mulh_step_if.ctrl          step,
  output logic               ready_o,
  output logic               multicycle_o
);
  import mult_pkg::*;

  mulh_state_e state_q;
  mulh_state_e state_d;
  // Store the accumulate carry at the end of this step
  logic        save;
  // Saved carry forced to zero
  logic        clear_carry;
  logic        carry_q;

  ////////////////////////////////////////////////////////////
  // Step sequencing
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    step.active      = 1'b1;
    step.imm         = '0;
    step.subword     = 2'b00;
    step.signed_sel  = 2'b00;
    step.shift_arith = 1'b0;
    ready_o          = 1'b0;
    multicycle_o     = 1'b0;
    save             = 1'b0;
    clear_carry      = 1'b0;

    case (state_q)
      IDLE: begin
        step.active = 1'b0;
        ready_o     = 1'b1;
        // Start only on a high multiply
        if (enable_i && (operator_i == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end

      STEP0: begin
        // AL x BL, both unsigned, never overflows
        multicycle_o = 1'b1;
        step.imm     = IMM_W'(MULH_SHIFT);
        state_d      = STEP1;
      end

      STEP1: begin
        // AL x BH, signed only if B is signed
        multicycle_o     = 1'b1;
        step.signed_sel  = {short_signed_i[1], 1'b0};
        step.subword     = 2'b10;
        step.shift_arith = 1'b1;
        // 33-bit result, keep bit 32 as sign extension
        save             = 1'b1;
        state_d          = STEP2;
      end

      STEP2: begin
        // AH x BL, signed only if A is signed
        multicycle_o     = 1'b1;
        step.signed_sel  = {1'b0, short_signed_i[0]};
        step.subword     = 2'b01;
        step.imm         = IMM_W'(MULH_SHIFT);
        step.shift_arith = 1'b1;
        // Upper bits shifted back in, carry not needed afterwards
        save             = 1'b1;
        clear_carry      = 1'b1;
        state_d          = FINISH;
      end

      FINISH: begin
        // AH x BH gives the high word
        step.signed_sel = short_signed_i;
        step.subword    = 2'b11;
        ready_o         = 1'b1;
        // Hold until the pipeline takes the result
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // State and carry registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (save) begin
        carry_q <= ~clear_carry & step.mac_carry;
      end else if (ex_ready_i) begin
        // Next instruction starts with a clean carry
        carry_q <= 1'b0;
      end
    end
  end

  assign step.state   = state_q;
  assign step.carry_q = carry_q;

endmodule

//--- verilog/mulh_step_if.sv
// Step controls and carry between the high-multiply FSM and the subword datapath
`timescale 1ns/1ps

interface mulh_step_if;
  import mult_pkg::*;

  // High multiply in a step or in FINISH
  logic             active;
  mulh_state_e      state;
  // Step shift amount
  logic [IMM_W-1:0] imm;
  // Half select, bit 0 for A and bit 1 for B
  logic [1:0]       subword;
  logic [1:0]       signed_sel;
  logic             shift_arith;
  // Stored carry, top bit of operand C
  logic             carry_q;
  // Bit 32 of the accumulate sum
  logic             mac_carry;

  modport ctrl (
    output active, state, imm, subword, signed_sel, shift_arith, carry_q,
    input  mac_carry
  );

  modport dp (
    input  active, state, imm, subword, signed_sel, shift_arith, carry_q,
    output mac_carry
  );

endinterface

//--- verilog/mult_pkg.sv
// Operator and high-multiply state encodings
// Width constants shared by the subword multiplier
package mult_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Full data word
  localparam int DATA_W = 32;
  // One subword lane
  localparam int HALF_W = 16;
  // Shift immediate
  localparam int IMM_W = 5;

  // Right shift applied in STEP0 and STEP2 of the high multiply
  localparam int MULH_SHIFT = 16;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Multiplier operator codes as issued by the decoder
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101,
    MUL_H     = 3'b110
  } mult_op_e;

  // High-multiply sequencer states
  typedef enum logic [2:0] {
    IDLE,
    STEP0,
    STEP1,
    STEP2,
    FINISH
  } mulh_state_e;

endpackage

//--- verilog/short_mac_unit.sv
// 16-bit subword multiply-accumulate with rounding and right shift
// Holds the partial result between high-multiply steps
`timescale 1ns/1ps

module short_mac_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  mult_pkg::mult_op_e          operator_i,
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  input  logic [mult_pkg::IMM_W-1:0]  imm_i,
  input  logic                        short_subword_i,
  input  logic [1:0]                  short_signed_i,
  mulh_step_if.dp                     step,
  output logic [mult_pkg::DATA_W-1:0] short_result_o
);
  import mult_pkg::*;

  // Operands carry one extra sign bit
  logic [HALF_W:0]   mac_op_a;
  logic [HALF_W:0]   mac_op_b;
  logic [DATA_W:0]   mac_op_c;
  logic [DATA_W+1:0] mac_mul;
  logic [DATA_W+1:0] mac_sum;
  logic [DATA_W-1:0] round_tmp;
  logic [DATA_W-1:0] round_val;
  logic [DATA_W+1:0] shifted;
  // Step result fed back as accumulator
  logic [DATA_W-1:0] partial_q;
  logic [IMM_W-1:0]  sel_imm;
  logic [1:0]        sel_subword;
  logic [1:0]        sel_signed;
  logic              sel_arith;
  logic              sum_msb1;
  logic              sum_msb0;

  // Controls come from the FSM during the high multiply
  assign sel_imm     = step.active ? step.imm         : imm_i;
  assign sel_subword = step.active ? step.subword     : {2{short_subword_i}};
  assign sel_signed  = step.active ? step.signed_sel  : short_signed_i;
  assign sel_arith   = step.active ? step.shift_arith : short_signed_i[0];

  // Half the shift weight, only for the rounding variant
  assign round_tmp = DATA_W'(1) << imm_i;
  assign round_val = (operator_i == MUL_IR) ? {1'b0, round_tmp[DATA_W-1:1]} : '0;

  // Half select
  assign mac_op_a[HALF_W-1:0] = sel_subword[0] ? op_a_i[DATA_W-1:HALF_W] : op_a_i[HALF_W-1:0];
  assign mac_op_b[HALF_W-1:0] = sel_subword[1] ? op_b_i[DATA_W-1:HALF_W] : op_b_i[HALF_W-1:0];

  // Sign extension, bit 0 for A and bit 1 for B
  assign mac_op_a[HALF_W] = sel_signed[0] & mac_op_a[HALF_W-1];
  assign mac_op_b[HALF_W] = sel_signed[1] & mac_op_b[HALF_W-1];

  // Carry joined with the partial result while stepping
  assign mac_op_c = step.active ? {step.carry_q, partial_q} : {op_c_i[DATA_W-1], op_c_i};

  assign mac_mul = $signed(mac_op_a) * $signed(mac_op_b);
  assign mac_sum = $signed(mac_op_c) + $signed(mac_mul) + $signed(round_val);

  // Steps keep the 34-bit sum, plain ops extend from bit 31
  assign sum_msb1 = step.active ? mac_sum[DATA_W+1] : mac_sum[DATA_W-1];
  assign sum_msb0 = step.active ? mac_sum[DATA_W]   : mac_sum[DATA_W-1];

  assign shifted = $signed({sel_arith & sum_msb1, sel_arith & sum_msb0,
                            mac_sum[DATA_W-1:0]}) >>> sel_imm;

  assign short_result_o = shifted[DATA_W-1:0];
  assign step.mac_carry = mac_sum[DATA_W];

  // Partial register, cleared between operations
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      partial_q <= '0;
    end else begin
      case (step.state)
        IDLE:                partial_q <= '0;
        STEP0, STEP1, STEP2: partial_q <= shifted[DATA_W-1:0];
        // FINISH keeps the last step so the result holds
        default:             partial_q <= partial_q;
      endcase
    end
  end

endmodule

//--- verilog/subword_mult.sv
// Subword multiply-accumulate unit top level
// Instances of the MAC datapaths and result selection by operator
`timescale 1ns/1ps

module subword_mult (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        enable_i,
  input  mult_pkg::mult_op_e          operator_i,
  // Shared operands
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  input  logic [mult_pkg::IMM_W-1:0]  imm_i,
  // Subword controls
  input  logic                        short_subword_i,
  input  logic [1:0]                  short_signed_i,
  input  logic [1:0]                  dot_signed_i,
  // Back-pressure from the pipeline
  input  logic                        ex_ready_i,
  output logic [mult_pkg::DATA_W-1:0] result_o,
  output logic                        ready_o,
  output logic                        multicycle_o
);
  import mult_pkg::*;

  logic [DATA_W-1:0] int_result;
  logic [DATA_W-1:0] short_result;
  logic [DATA_W-1:0] dot8_result;
  logic [DATA_W-1:0] dot16_result;

  // Step controls between the FSM and the short datapath
  mulh_step_if u_step ();

  ////////////////////////////////////////////////////////////
  // High-multiply sequencer
  ////////////////////////////////////////////////////////////

  mulh_ctrl u_mulh_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (enable_i),
    .operator_i     (operator_i),
    .short_signed_i (short_signed_i),
    .ex_ready_i     (ex_ready_i),
    .step           (u_step.ctrl),
    .ready_o        (ready_o),
    .multicycle_o   (multicycle_o)
  );

  ////////////////////////////////////////////////////////////
  // Datapaths
  ////////////////////////////////////////////////////////////

  short_mac_unit u_short_mac (
    .clk             (clk),
    .rst_n           (rst_n),
    .operator_i      (operator_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .imm_i           (imm_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .step            (u_step.dp),
    .short_result_o  (short_result)
  );

  int_mac_unit u_int_mac (
    .operator_i   (operator_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .op_c_i       (op_c_i),
    .int_result_o (int_result)
  );

  // Dot products always present
  dot_mac_unit u_dot_mac (
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .op_c_i         (op_c_i),
    .dot_signed_i   (dot_signed_i),
    .dot8_result_o  (dot8_result),
    .dot16_result_o (dot16_result)
  );

  // Result select, unused code gives zero
  always_comb begin
    case (operator_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT16:            result_o = dot16_result;
      default:              result_o = '0;
    endcase
  end

endmodule
